/* logic/chroma_downsample.sv */
`timescale 1ns/100ps
module chroma_downsample (
	input  logic              sys_clk,
	input  logic              Sys_Rst_N,
	input  logic              i_hs,
	input  logic              i_vs,
	input  logic              i_de,
	input  video_pkg::pixel_t i_y,
	input  video_pkg::pixel_t i_cb,
	input  video_pkg::pixel_t i_cr,
	output logic              o_hs,
	output logic              o_vs,
	output logic              o_de,
	output video_pkg::pixel_t o_y,
	output video_pkg::pixel_t o_c
);

	logic phase;                                           // 0 even, 1 odd within a de run

	//==============================
	// Pixel phase
	//==============================
	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N)
			phase <= 1'b0;
		else if (i_de)
			phase <= ~phase;                               // Alternate per pixel
		else
			phase <= 1'b0;                                 // Every run starts even
	end

	//==============================
	// Output register
	//==============================
	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			o_hs <= 1'b0;
			o_vs <= 1'b0;
			o_de <= 1'b0;
		end else begin
			o_hs <= i_hs;                                  // One cycle, matches LAT_DOWN
			o_vs <= i_vs;
			o_de <= i_de;
		end
	end

	// Luma untouched, chroma decimated by 2
	always_ff @(posedge sys_clk) begin
		o_y <= i_y;
		if (phase)
			o_c <= i_cr;                                   // Odd pixel carries Cr
		else
			o_c <= i_cb;                                   // Even pixel carries Cb
	end

endmodule

/* logic/chroma_upsample.sv */
`timescale 1ns/100ps
module chroma_upsample (
	input  logic              sys_clk,
	input  logic              Sys_Rst_N,
	input  logic              i_hs,
	input  logic              i_vs,
	input  logic              i_de,
	input  video_pkg::pixel_t i_y,
	input  video_pkg::pixel_t i_c,
	output logic              o_hs,
	output logic              o_vs,
	output logic              o_de,
	output video_pkg::pixel_t o_y,
	output video_pkg::pixel_t o_cb,
	output video_pkg::pixel_t o_cr
);

	logic [video_pkg::LAT_UP-1:0] hs_pipe;                 // Sync delay line
	logic [video_pkg::LAT_UP-1:0] vs_pipe;
	logic [video_pkg::LAT_UP-1:0] de_pipe;

	logic              phase;                              // Phase of current input pixel
	logic              odd_d1;                             // Phase of held pixel
	video_pkg::pixel_t y_d1;                               // Held pixel
	video_pkg::pixel_t c_d1;

	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			hs_pipe <= '0;
			vs_pipe <= '0;
			de_pipe <= '0;
			phase   <= 1'b0;
			odd_d1  <= 1'b0;
		end else begin
			hs_pipe <= {hs_pipe[video_pkg::LAT_UP-2:0], i_hs};
			vs_pipe <= {vs_pipe[video_pkg::LAT_UP-2:0], i_vs};
			de_pipe <= {de_pipe[video_pkg::LAT_UP-2:0], i_de};
			phase   <= i_de ? ~phase : 1'b0;               // Same rule as downsampler
			odd_d1  <= phase;
		end
	end

	assign o_hs = hs_pipe[video_pkg::LAT_UP-1];
	assign o_vs = vs_pipe[video_pkg::LAT_UP-1];
	assign o_de = de_pipe[video_pkg::LAT_UP-1];

	//==============================
	// Pair reconstruction
	//==============================
	always_ff @(posedge sys_clk) begin
		y_d1 <= i_y;                                       // Wait one pixel for the Cr
		c_d1 <= i_c;
	end

	// Even pixel leaves when its odd partner is on the input
	always_ff @(posedge sys_clk) begin
		o_y <= y_d1;
		if (odd_d1) begin
			o_cb <= o_cb;                                  // Cb from the even partner
			o_cr <= c_d1;                                  // Own Cr
		end else begin
			o_cb <= c_d1;                                  // Own Cb
			if (i_de)
				o_cr <= i_c;                               // Partner's Cr
			else
				o_cr <= video_pkg::CHROMA_MID;             // Run ended on even pixel
		end
	end

endmodule

/* logic/frame_window.sv */
`timescale 1ns/100ps
module frame_window (
	input  logic                 sys_clk,
	input  logic                 Sys_Rst_N,
	input  logic                 i_hs,
	input  logic                 i_vs,
	input  logic                 i_de,
	input  video_pkg::pixel_t    i_r,
	input  video_pkg::pixel_t    i_g,
	input  video_pkg::pixel_t    i_b,
	input  video_pkg::coord_t    i_win_start_x,
	input  video_pkg::coord_t    i_win_start_y,
	input  video_pkg::coord_t    i_win_end_x,
	input  video_pkg::coord_t    i_win_end_y,
	input  video_pkg::win_mode_e i_win_mode,
	output logic                 o_hs,
	output logic                 o_vs,
	output logic                 o_de,
	output video_pkg::pixel_t    o_r,
	output video_pkg::pixel_t    o_g,
	output video_pkg::pixel_t    o_b
);

	video_pkg::coord_t    win_start_x;                     // Frame-stable window copy
	video_pkg::coord_t    win_start_y;
	video_pkg::coord_t    win_end_x;
	video_pkg::coord_t    win_end_y;
	video_pkg::win_mode_e win_mode;

	video_pkg::coord_t    x_cnt;                           // Column of current input pixel
	video_pkg::coord_t    y_cnt;                           // Line of current input pixel
	logic                 de_prev;                         // For de falling edge
	logic                 in_win;
	logic                 pass;

	//==============================
	// Window parameters
	//==============================
	// Only sampled during vsync so a frame never sees a half-updated window
	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			win_start_x <= '0;
			win_start_y <= '0;
			win_end_x   <= video_pkg::H_VALID;
			win_end_y   <= video_pkg::V_VALID;
			win_mode    <= video_pkg::WIN_FULL;
		end else if (i_vs) begin
			win_start_x <= i_win_start_x;
			win_start_y <= i_win_start_y;
			win_end_x   <= i_win_end_x;
			win_end_y   <= i_win_end_y;
			win_mode    <= i_win_mode;
		end
	end

	//==============================
	// Position counters
	//==============================
	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			x_cnt   <= '0;
			y_cnt   <= '0;
			de_prev <= 1'b0;
		end else begin
			de_prev <= i_de;
			if (i_de)
				x_cnt <= x_cnt + 12'd1;                    // Next column
			else
				x_cnt <= '0;                               // Blanking restarts the line
			if (i_vs)
				y_cnt <= '0;                               // New frame
			else if (de_prev && !i_de)
				y_cnt <= y_cnt + 12'd1;                    // End of an active line
		end
	end

	assign in_win = (x_cnt >= win_start_x) && (x_cnt < win_end_x) &&
	                (y_cnt >= win_start_y) && (y_cnt < win_end_y);
	assign pass   = (win_mode == video_pkg::WIN_FULL) || in_win;

	//==============================
	// Output register
	//==============================
	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			o_hs <= 1'b0;
			o_vs <= 1'b0;
			o_de <= 1'b0;
		end else begin
			o_hs <= i_hs;
			o_vs <= i_vs;
			o_de <= i_de && pass;                          // Gated by window
		end
	end

	always_ff @(posedge sys_clk) begin
		o_r <= i_r;                                        // Colour passes regardless
		o_g <= i_g;
		o_b <= i_b;
	end

endmodule

/* logic/rgb_to_ycbcr.sv */
`timescale 1ns/100ps
module rgb_to_ycbcr (
	input  logic              sys_clk,
	input  logic              Sys_Rst_N,
	input  logic              i_hs,
	input  logic              i_vs,
	input  logic              i_de,
	input  video_pkg::pixel_t i_r,
	input  video_pkg::pixel_t i_g,
	input  video_pkg::pixel_t i_b,
	output logic              o_hs,
	output logic              o_vs,
	output logic              o_de,
	output video_pkg::pixel_t o_y,
	output video_pkg::pixel_t o_cb,
	output video_pkg::pixel_t o_cr
);

	logic [video_pkg::LAT_CSC-1:0] hs_pipe;                // Sync delay line
	logic [video_pkg::LAT_CSC-1:0] vs_pipe;
	logic [video_pkg::LAT_CSC-1:0] de_pipe;

	logic [15:0]        p_yr, p_yg, p_yb;                  // Stage 1 products
	logic [15:0]        p_cbr, p_cbg, p_cbb;
	logic [15:0]        p_crr, p_crg, p_crb;

	logic [15:0]        y_sum;                             // Stage 2 sums
	logic signed [16:0] cb_sum;
	logic signed [16:0] cr_sum;

	logic signed [11:0] cb_val;
	logic signed [11:0] cr_val;

	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			hs_pipe <= '0;
			vs_pipe <= '0;
			de_pipe <= '0;
		end else begin
			hs_pipe <= {hs_pipe[video_pkg::LAT_CSC-2:0], i_hs};
			vs_pipe <= {vs_pipe[video_pkg::LAT_CSC-2:0], i_vs};
			de_pipe <= {de_pipe[video_pkg::LAT_CSC-2:0], i_de};
		end
	end

	assign o_hs = hs_pipe[video_pkg::LAT_CSC-1];
	assign o_vs = vs_pipe[video_pkg::LAT_CSC-1];
	assign o_de = de_pipe[video_pkg::LAT_CSC-1];

	//==============================
	// Stage 1 products
	//==============================
	always_ff @(posedge sys_clk) begin
		p_yr  <= 16'(i_r) * 16'(video_pkg::Y_R);
		p_yg  <= 16'(i_g) * 16'(video_pkg::Y_G);
		p_yb  <= 16'(i_b) * 16'(video_pkg::Y_B);
		p_cbr <= 16'(i_r) * 16'(video_pkg::CB_R);
		p_cbg <= 16'(i_g) * 16'(video_pkg::CB_G);
		p_cbb <= 16'(i_b) * 16'(video_pkg::CB_B);
		p_crr <= 16'(i_r) * 16'(video_pkg::CR_R);
		p_crg <= 16'(i_g) * 16'(video_pkg::CR_G);
		p_crb <= 16'(i_b) * 16'(video_pkg::CR_B);
	end

	//==============================
	// Stage 2 sums
	//==============================
	always_ff @(posedge sys_clk) begin
		y_sum  <= p_yr + p_yg + p_yb;                      // Weights total 256, no overflow
		cb_sum <= $signed({1'b0, p_cbb}) - $signed({1'b0, p_cbr}) - $signed({1'b0, p_cbg});
		cr_sum <= $signed({1'b0, p_crr}) - $signed({1'b0, p_crg}) - $signed({1'b0, p_crb});
	end

	// Floor shift then recentre on mid grey
	assign cb_val = 12'(cb_sum >>> 8) + signed'({4'd0, video_pkg::CHROMA_MID});
	assign cr_val = 12'(cr_sum >>> 8) + signed'({4'd0, video_pkg::CHROMA_MID});

	//==============================
	// Stage 3 scale and clamp
	//==============================
	always_ff @(posedge sys_clk) begin
		o_y  <= y_sum[15:8];                               // Max 255 by construction
		o_cb <= video_pkg::clamp_pixel(cb_val);
		o_cr <= video_pkg::clamp_pixel(cr_val);
	end

endmodule

/* logic/video_color_top.sv */
`timescale 1ns/100ps
module video_color_top (
	input  logic                 sys_clk,
	input  logic                 Sys_Rst_N,
	input  logic                 i_hs,
	input  logic                 i_vs,
	input  logic                 i_de,
	input  video_pkg::pixel_t    i_r,
	input  video_pkg::pixel_t    i_g,
	input  video_pkg::pixel_t    i_b,
	input  video_pkg::coord_t    i_win_start_x,
	input  video_pkg::coord_t    i_win_start_y,
	input  video_pkg::coord_t    i_win_end_x,
	input  video_pkg::coord_t    i_win_end_y,
	input  video_pkg::win_mode_e i_win_mode,
	output logic                 o_hs,
	output logic                 o_vs,
	output logic                 o_de,
	output video_pkg::pixel_t    o_r,
	output video_pkg::pixel_t    o_g,
	output video_pkg::pixel_t    o_b
);

	//==============================
	// Stage wiring
	//==============================
	logic              win_hs, win_vs, win_de;             // Window out
	video_pkg::pixel_t win_r, win_g, win_b;
	logic              h444_hs, h444_vs, h444_de;          // YCbCr 4:4:4 after forward CSC
	video_pkg::pixel_t y_444, cb_444, cr_444;
	logic              h422_hs, h422_vs, h422_de;          // Decimated stream
	video_pkg::pixel_t y_422, c_422;
	logic              up_hs, up_vs, up_de;                // Restored 4:4:4
	video_pkg::pixel_t y_up, cb_up, cr_up;

	frame_window u_frame_window (
		.sys_clk       (sys_clk),       .Sys_Rst_N     (Sys_Rst_N),
		.i_hs          (i_hs),          .i_vs          (i_vs),          .i_de (i_de),
		.i_r           (i_r),           .i_g           (i_g),           .i_b  (i_b),
		.i_win_start_x (i_win_start_x), .i_win_start_y (i_win_start_y),
		.i_win_end_x   (i_win_end_x),   .i_win_end_y   (i_win_end_y),
		.i_win_mode    (i_win_mode),
		.o_hs          (win_hs),        .o_vs          (win_vs),        .o_de (win_de),
		.o_r           (win_r),         .o_g           (win_g),         .o_b  (win_b)
	);

	rgb_to_ycbcr u_rgb_to_ycbcr (
		.sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
		.i_hs    (win_hs),  .i_vs      (win_vs),   .i_de (win_de),
		.i_r     (win_r),   .i_g       (win_g),    .i_b  (win_b),
		.o_hs    (h444_hs), .o_vs      (h444_vs),  .o_de (h444_de),
		.o_y     (y_444),   .o_cb      (cb_444),   .o_cr (cr_444)
	);

	chroma_downsample u_chroma_downsample (
		.sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
		.i_hs    (h444_hs), .i_vs      (h444_vs),  .i_de (h444_de),
		.i_y     (y_444),   .i_cb      (cb_444),   .i_cr (cr_444),
		.o_hs    (h422_hs), .o_vs      (h422_vs),  .o_de (h422_de),
		.o_y     (y_422),   .o_c       (c_422)
	);

	chroma_upsample u_chroma_upsample (
		.sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
		.i_hs    (h422_hs), .i_vs      (h422_vs),  .i_de (h422_de),
		.i_y     (y_422),   .i_c       (c_422),
		.o_hs    (up_hs),   .o_vs      (up_vs),    .o_de (up_de),
		.o_y     (y_up),    .o_cb      (cb_up),    .o_cr (cr_up)
	);

	ycbcr_to_rgb u_ycbcr_to_rgb (
		.sys_clk (sys_clk), .Sys_Rst_N (Sys_Rst_N),
		.i_hs    (up_hs),   .i_vs      (up_vs),    .i_de (up_de),
		.i_y     (y_up),    .i_cb      (cb_up),    .i_cr (cr_up),
		.o_hs    (o_hs),    .o_vs      (o_vs),     .o_de (o_de),
		.o_r     (o_r),     .o_g       (o_g),      .o_b  (o_b)
	);

endmodule

/* logic/video_pkg.sv */
package video_pkg;

	//==============================
	// Widths
	//==============================
	typedef logic [7:0]  pixel_t;                          // One colour or luma/chroma sample
	typedef logic [11:0] coord_t;                          // Pixel or line coordinate

	localparam coord_t H_VALID = 12'd1920;                 // Active pixels per line
	localparam coord_t V_VALID = 12'd1080;                 // Active lines per frame

	localparam pixel_t CHROMA_MID = 8'd128;                // Neutral chroma

	//==============================
	// Colour coefficients
	//==============================
	// Forward, 8-bit fractions of 256
	localparam logic [7:0] Y_R  = 8'd77;
	localparam logic [7:0] Y_G  = 8'd150;
	localparam logic [7:0] Y_B  = 8'd29;
	localparam logic [7:0] CB_R = 8'd43;
	localparam logic [7:0] CB_G = 8'd85;
	localparam logic [7:0] CB_B = 8'd128;
	localparam logic [7:0] CR_R = 8'd128;
	localparam logic [7:0] CR_G = 8'd107;
	localparam logic [7:0] CR_B = 8'd21;

	// Inverse, signed so they multiply centred chroma directly
	localparam logic signed [9:0] R_CR = 10'sd359;
	localparam logic signed [9:0] G_CB = 10'sd88;
	localparam logic signed [9:0] G_CR = 10'sd183;
	localparam logic signed [9:0] B_CB = 10'sd454;

	//==============================
	// Stage latencies
	//==============================
	localparam int LAT_WINDOW   = 1;
	localparam int LAT_CSC      = 3;                       // Each colour converter
	localparam int LAT_DOWN     = 1;
	localparam int LAT_UP       = 2;
	localparam int PIPE_LATENCY = LAT_WINDOW + 2 * LAT_CSC + LAT_DOWN + LAT_UP;

	typedef enum logic {
		WIN_CROP = 1'b0,                                   // Only the window passes
		WIN_FULL = 1'b1                                    // Whole frame passes
	} win_mode_e;

	// Saturate a signed intermediate to the 0..255 range
	function automatic pixel_t clamp_pixel(input logic signed [11:0] v);
		if (v < 0)
			return 8'h00;                                  // Underflow
		else if (v > 12'sd255)
			return 8'hff;                                  // Overflow
		else
			return v[7:0];
	endfunction

endpackage

/* logic/ycbcr_to_rgb.sv */
`timescale 1ns/100ps
module ycbcr_to_rgb (
	input  logic              sys_clk,
	input  logic              Sys_Rst_N,
	input  logic              i_hs,
	input  logic              i_vs,
	input  logic              i_de,
	input  video_pkg::pixel_t i_y,
	input  video_pkg::pixel_t i_cb,
	input  video_pkg::pixel_t i_cr,
	output logic              o_hs,
	output logic              o_vs,
	output logic              o_de,
	output video_pkg::pixel_t o_r,
	output video_pkg::pixel_t o_g,
	output video_pkg::pixel_t o_b
);

	logic [video_pkg::LAT_CSC-1:0] hs_pipe;                // Sync delay line
	logic [video_pkg::LAT_CSC-1:0] vs_pipe;
	logic [video_pkg::LAT_CSC-1:0] de_pipe;

	video_pkg::pixel_t  y_d1;                              // Luma follows the chroma math
	video_pkg::pixel_t  y_d2;
	logic signed [8:0]  cb_off;                            // Chroma centred on zero
	logic signed [8:0]  cr_off;

	logic signed [17:0] r_prod;                            // Stage 2 products
	logic signed [17:0] g_prod;
	logic signed [17:0] b_prod;

	logic signed [11:0] y_ext;
	logic signed [11:0] r_val;
	logic signed [11:0] g_val;
	logic signed [11:0] b_val;

	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			hs_pipe <= '0;
			vs_pipe <= '0;
			de_pipe <= '0;
		end else begin
			hs_pipe <= {hs_pipe[video_pkg::LAT_CSC-2:0], i_hs};
			vs_pipe <= {vs_pipe[video_pkg::LAT_CSC-2:0], i_vs};
			de_pipe <= {de_pipe[video_pkg::LAT_CSC-2:0], i_de};
		end
	end

	assign o_hs = hs_pipe[video_pkg::LAT_CSC-1];
	assign o_vs = vs_pipe[video_pkg::LAT_CSC-1];
	assign o_de = de_pipe[video_pkg::LAT_CSC-1];

	//==============================
	// Stage 1 remove offset
	//==============================
	always_ff @(posedge sys_clk) begin
		y_d1   <= i_y;
		cb_off <= $signed({1'b0, i_cb}) - $signed({1'b0, video_pkg::CHROMA_MID});
		cr_off <= $signed({1'b0, i_cr}) - $signed({1'b0, video_pkg::CHROMA_MID});
	end

	//==============================
	// Stage 2 scaled products
	//==============================
	always_ff @(posedge sys_clk) begin
		y_d2   <= y_d1;
		r_prod <= 18'(video_pkg::R_CR) * 18'(cr_off);
		g_prod <= 18'(video_pkg::G_CB) * 18'(cb_off) + 18'(video_pkg::G_CR) * 18'(cr_off);
		b_prod <= 18'(video_pkg::B_CB) * 18'(cb_off);
	end

	// Shift before adding Y and subtract the green term as a whole
	assign y_ext = {4'd0, y_d2};
	assign r_val = y_ext + 12'(r_prod >>> 8);
	assign g_val = y_ext - 12'(g_prod >>> 8);
	assign b_val = y_ext + 12'(b_prod >>> 8);

	//==============================
	// Stage 3 add and clamp
	//==============================
	always_ff @(posedge sys_clk) begin
		o_r <= video_pkg::clamp_pixel(r_val);              // Saturates strong reds
		o_g <= video_pkg::clamp_pixel(g_val);
		o_b <= video_pkg::clamp_pixel(b_val);              // Widest swing of the three
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the colour path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_video_color -f video_color_top.f \
	-Mdir obj_dir -o sim_video_color

status=0
./obj_dir/sim_video_color +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
	exit 1
fi
exit 0

/* testbench/tb_video_color.sv */
`timescale 1ns/100ps
module tb_video_color;

	localparam int H_SYNC     = 2;                         // hs pulse at start of blanking
	localparam int H_BLANK    = 6;
	localparam int H_ACT      = 16;                        // Even line width
	localparam int H_TOTAL    = H_BLANK + H_ACT;
	localparam int V_SYNC     = 2;                         // Lines with vs high
	localparam int V_ACT      = 6;
	localparam int WAIT_LIMIT = 200;                       // Cycles before a wait gives up
	localparam int IDLE_RUN   = video_pkg::PIPE_LATENCY + 2;

	logic                 sys_clk;
	logic                 Sys_Rst_N;
	logic                 i_hs;
	logic                 i_vs;
	logic                 i_de;
	video_pkg::pixel_t    i_r;
	video_pkg::pixel_t    i_g;
	video_pkg::pixel_t    i_b;
	video_pkg::coord_t    i_win_start_x;
	video_pkg::coord_t    i_win_start_y;
	video_pkg::coord_t    i_win_end_x;
	video_pkg::coord_t    i_win_end_y;
	video_pkg::win_mode_e i_win_mode;
	logic                 o_hs;
	logic                 o_vs;
	logic                 o_de;
	video_pkg::pixel_t    o_r;
	video_pkg::pixel_t    o_g;
	video_pkg::pixel_t    o_b;

	int          timeouts;
	int          tests_run;
	int          errs_seen;                                // Total at end of last test

	video_color_top dut0 (.*);

	always #50 sys_clk = ~sys_clk;                         // 100 ns period

	//==============================
	// Raster stimulus
	//==============================
	task automatic drive_line(input logic vs, input logic act, input logic [23:0] rgb);
		for (int i = 0; i < H_TOTAL; i++) begin
			@(negedge sys_clk);
			i_vs = vs;
			i_hs = (i < H_SYNC);
			i_de = act && (i >= H_BLANK);                  // Active part after blanking
			{i_r, i_g, i_b} = rgb;                         // Constant over the line
		end
	endtask

	// Black and white first to reach the clamps
	function automatic logic [23:0] pick_colour(input int n);
		if (n == 0)
			return 24'h000000;
		if (n == 1)
			return 24'hffffff;
		return 24'($urandom);
	endfunction

	task automatic drive_vsync();
		for (int n = 0; n < V_SYNC; n++)
			drive_line(1'b1, 1'b0, 24'h0);
	endtask

	task automatic drive_active(input int first, input int count);
		for (int n = first; n < first + count; n++)
			drive_line(1'b0, 1'b1, pick_colour(n));
	endtask

	task automatic drive_frame();
		drive_vsync();
		drive_active(0, V_ACT);
		drive_line(1'b0, 1'b0, 24'h0);                     // Trailing blank line
	endtask

	task automatic pick_window();
		int sx;
		int sy;
		sx = int'($urandom_range(0, 7));
		sy = int'($urandom_range(0, 2));
		i_win_start_x = video_pkg::coord_t'(sx);
		i_win_end_x   = video_pkg::coord_t'(sx + 2 * int'($urandom_range(1, 4)));
		i_win_start_y = video_pkg::coord_t'(sy);
		i_win_end_y   = video_pkg::coord_t'(sy + int'($urandom_range(1, 3)));
		i_win_mode    = video_pkg::WIN_CROP;
	endtask

	//==============================
	// Waits and reporting
	//==============================
	task automatic wait_idle(input string name);
		int idle;
		int cycles;
		idle   = 0;
		cycles = 0;
		while (idle < IDLE_RUN && cycles < WAIT_LIMIT) begin
			@(negedge sys_clk);
			cycles++;
			if (!o_de && !o_hs && !o_vs)
				idle++;
			else
				idle = 0;                                  // Still draining
		end
		if (idle < IDLE_RUN) begin
			timeouts++;
			$display("Timeout in %s: output stream did not go idle", name);
		end
	endtask

	task automatic finish_test(input string name);
		int now_errs;
		now_errs = dut0.u_asserts.err_cnt + timeouts;
		tests_run++;
		$display("Test %0d %s finished with %0d errors", tests_run, name, now_errs - errs_seen);
		errs_seen = now_errs;
	endtask

	initial begin
		void'($urandom(32'hc8c8_6256));
		sys_clk       = 1'b0;
		Sys_Rst_N     = 1'b0;
		i_hs          = 1'b0;
		i_vs          = 1'b0;
		i_de          = 1'b0;
		{i_r, i_g, i_b} = 24'h0;
		i_win_start_x = '0;
		i_win_start_y = '0;
		i_win_end_x   = video_pkg::H_VALID;
		i_win_end_y   = video_pkg::V_VALID;
		i_win_mode    = video_pkg::WIN_FULL;
		timeouts      = 0;
		tests_run     = 0;
		errs_seen     = 0;

		repeat (10) @(negedge sys_clk);
		Sys_Rst_N = 1'b1;
		drive_frame();
		wait_idle("reset");
		finish_test("reset");

		repeat (2) drive_frame();                          // Full mode colour lines
		wait_idle("colour_full");
		finish_test("colour_full");

		repeat (3) begin
			pick_window();                                 // Latched at the next vsync
			drive_frame();
		end
		wait_idle("crop_window");
		finish_test("crop_window");

		pick_window();
		drive_vsync();
		drive_active(0, 3);
		pick_window();                                     // Mid frame change held off
		drive_active(3, V_ACT - 3);
		drive_line(1'b0, 1'b0, 24'h0);
		drive_frame();                                     // New window from here
		wait_idle("frame_sync_params");
		finish_test("frame_sync_params");

		i_win_mode = video_pkg::WIN_FULL;
		drive_frame();
		wait_idle("full_after_crop");
		finish_test("full_after_crop");

		$display("Summary: %0d tests, %0d errors", tests_run, errs_seen);
		if (errs_seen == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* testbench/video_color_asserts.sv */
`timescale 1ns/100ps
module video_color_asserts (
	input logic                 sys_clk,
	input logic                 Sys_Rst_N,
	input logic                 i_hs,
	input logic                 i_vs,
	input logic                 i_de,
	input video_pkg::pixel_t    i_r,
	input video_pkg::pixel_t    i_g,
	input video_pkg::pixel_t    i_b,
	input video_pkg::coord_t    i_win_start_x,
	input video_pkg::coord_t    i_win_start_y,
	input video_pkg::coord_t    i_win_end_x,
	input video_pkg::coord_t    i_win_end_y,
	input video_pkg::win_mode_e i_win_mode,
	input logic                 o_hs,
	input logic                 o_vs,
	input logic                 o_de,
	input video_pkg::pixel_t    o_r,
	input video_pkg::pixel_t    o_g,
	input video_pkg::pixel_t    o_b
);

	localparam int PL = video_pkg::PIPE_LATENCY;           // Input to output delay

	int reset_errs = 0;                                    // One counter per property
	int sync_errs = 0;
	int de_errs = 0;
	int colour_errs = 0;
	int err_cnt;                                           // Read by the testbench
	int rst_age;                                           // Cycles since reset release

	video_pkg::coord_t    x_pos;                           // Model of input position
	video_pkg::coord_t    y_pos;
	video_pkg::coord_t    ws_x;                            // Model of latched window
	video_pkg::coord_t    ws_y;
	video_pkg::coord_t    we_x;
	video_pkg::coord_t    we_y;
	video_pkg::win_mode_e mode_q;
	logic                 de_q;                            // Previous input de
	logic [23:0]          rgb_q;                           // Previous input colour
	logic [23:0]          in_rgb;
	logic [23:0]          exp_rgb;                         // Expected round trip colour
	logic                 in_window;
	logic                 exp_de;
	logic                 flat;                            // Pixel matches its predecessor

	//==============================
	// Reference colour model
	//==============================
	function automatic int saturate(input int v);
		if (v < 0)
			return 0;
		if (v > 255)
			return 255;
		return v;
	endfunction

	// Forward to YCbCr then back, all in plain integers
	function automatic logic [23:0] round_trip(input logic [23:0] rgb);
		int r, g, b;
		int y, cb, cr;
		int ro, go, bo;
		r  = int'(rgb[23:16]);
		g  = int'(rgb[15:8]);
		b  = int'(rgb[7:0]);
		y  = saturate((77 * r + 150 * g + 29 * b) >>> 8);
		cb = saturate(128 + ((128 * b - 43 * r - 85 * g) >>> 8));
		cr = saturate(128 + ((128 * r - 107 * g - 21 * b) >>> 8));
		ro = saturate(y + ((359 * (cr - 128)) >>> 8));
		go = saturate(y - ((88 * (cb - 128) + 183 * (cr - 128)) >>> 8));
		bo = saturate(y + ((454 * (cb - 128)) >>> 8));
		return {ro[7:0], go[7:0], bo[7:0]};
	endfunction

	//==============================
	// Position and window model
	//==============================
	always_ff @(posedge sys_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			rst_age <= 0;
			x_pos   <= '0;
			y_pos   <= '0;
			de_q    <= 1'b0;
			rgb_q   <= '0;
			ws_x    <= '0;
			ws_y    <= '0;
			we_x    <= video_pkg::H_VALID;
			we_y    <= video_pkg::V_VALID;
			mode_q  <= video_pkg::WIN_FULL;
		end else begin
			if (rst_age < 1000)
				rst_age <= rst_age + 1;                    // Saturating
			de_q  <= i_de;
			rgb_q <= in_rgb;
			x_pos <= i_de ? x_pos + 12'd1 : 12'd0;         // Column within the run
			if (i_vs)
				y_pos <= '0;
			else if (de_q && !i_de)
				y_pos <= y_pos + 12'd1;                    // Line ended
			if (i_vs) begin
				ws_x   <= i_win_start_x;                   // Only during vsync
				ws_y   <= i_win_start_y;
				we_x   <= i_win_end_x;
				we_y   <= i_win_end_y;
				mode_q <= i_win_mode;
			end
		end
	end

	assign in_rgb    = {i_r, i_g, i_b};
	assign exp_rgb   = round_trip(in_rgb);
	assign flat      = i_de && de_q && (in_rgb == rgb_q);
	assign in_window = (x_pos >= ws_x) && (x_pos < we_x) && (y_pos >= ws_y) && (y_pos < we_y);
	assign exp_de    = i_de && ((mode_q == video_pkg::WIN_FULL) || in_window);
	assign err_cnt   = reset_errs + sync_errs + de_errs + colour_errs;

	//==============================
	// Properties
	//==============================
	a_reset_quiet: assert property (@(posedge sys_clk)
		(rst_age < PL) |-> (!o_de && !o_hs && !o_vs))
	else begin
		reset_errs++;
		$error("ERROR %0t: output sync or de active before the pipeline filled", $time);
	end

	a_sync_align: assert property (@(posedge sys_clk) disable iff (!Sys_Rst_N)
		(rst_age >= PL) |-> ((o_hs == $past(i_hs, PL)) && (o_vs == $past(i_vs, PL))))
	else begin
		sync_errs++;
		$error("ERROR %0t: o_hs or o_vs not aligned with delayed input", $time);
	end

	a_window_de: assert property (@(posedge sys_clk) disable iff (!Sys_Rst_N)
		(rst_age >= PL) |-> (o_de == $past(exp_de, PL)))
	else begin
		de_errs++;
		$error("ERROR %0t: o_de differs from the window rule", $time);
	end

	// Centre pixel of three equal colours, so its pair partner matches
	a_colour: assert property (@(posedge sys_clk) disable iff (!Sys_Rst_N)
		(rst_age > PL && o_de && $past(mode_q, PL) == video_pkg::WIN_FULL &&
		 $past(flat, PL) && $past(flat, PL - 1)) |-> ({o_r, o_g, o_b} == $past(exp_rgb, PL)))
	else begin
		colour_errs++;
		$error("ERROR %0t: colour %h differs from reference %h", $time,
			{o_r, o_g, o_b}, $past(exp_rgb, PL));
	end

endmodule

bind video_color_top video_color_asserts u_asserts (.*);

/* video_color_top.f */
logic/video_pkg.sv
logic/frame_window.sv
logic/rgb_to_ycbcr.sv
logic/chroma_downsample.sv
logic/chroma_upsample.sv
logic/ycbcr_to_rgb.sv
logic/video_color_top.sv
testbench/video_color_asserts.sv
testbench/tb_video_color.sv
